// ==== include/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data bus width, one byte per transfer
`define CORE_DATA_W 8

// address bus width
`define CORE_ADDR_W 16

// first opcode fetch after reset, no vector fetch
`define CORE_RESET_PC 16'h0200

// high address byte for zp stores
`define CORE_ZERO_PAGE 8'h00

`endif

// ==== source/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // timing states of the sequencer
    // T1 is always the opcode fetch
    typedef enum logic [1:0] {
        T1,
        T2,
        T3,
        T_JAM
    } state_e;

    // instruction class, picks the cycle sequence
    typedef enum logic [2:0] {
        OP_IMM,
        OP_IMPL,
        OP_STZ,
        OP_JMP,
        OP_BAD
    } op_class_e;

    // alu function applied to src and memory operand
    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADC,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_INC
    } alu_op_e;

    // register select for alu source, destination and store data
    // REG_M is the byte on the data bus
    typedef enum logic [2:0] {
        REG_NONE,
        REG_A,
        REG_X,
        REG_Y,
        REG_M,
        REG_Z
    } reg_sel_e;

endpackage

`default_nettype wire

// ==== source/decode_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

interface decode_if;

    // opcode latched in T1
    logic [`CORE_DATA_W-1:0] ir;

    // decoded fields
    core_pkg::op_class_e op_class;
    core_pkg::alu_op_e   alu_op;
    core_pkg::reg_sel_e  src_sel;
    core_pkg::reg_sel_e  dst_sel;
    // carry write enable and value for CLC/SEC
    logic                upd_c;
    logic                set_c_val;

    // decoder: reads ir, drives all fields
    modport dec_mp (
        input  ir,
        output op_class, alu_op, src_sel, dst_sel, upd_c, set_c_val
    );

    // sequencer owns ir, only needs the class
    modport seq_mp (
        output ir,
        input  op_class
    );

    // execute side
    modport exe_mp (
        input alu_op, src_sel, dst_sel, upd_c, set_c_val
    );

endinterface

`default_nettype wire

// ==== source/op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module op_decode (
    decode_if.dec_mp dec
);

    import core_pkg::*;

    // opcode bytes of the kept instruction set
    typedef enum logic [`CORE_DATA_W-1:0] {
        OPC_LDA_IMM = 8'hA9,
        OPC_LDX_IMM = 8'hA2,
        OPC_LDY_IMM = 8'hA0,
        OPC_ADC_IMM = 8'h69,
        OPC_AND_IMM = 8'h29,
        OPC_ORA_IMM = 8'h09,
        OPC_EOR_IMM = 8'h49,
        OPC_INX     = 8'hE8,
        OPC_INY     = 8'hC8,
        OPC_TAX     = 8'hAA,
        OPC_TAY     = 8'hA8,
        OPC_TXA     = 8'h8A,
        OPC_TYA     = 8'h98,
        OPC_CLC     = 8'h18,
        OPC_SEC     = 8'h38,
        OPC_NOP     = 8'hEA,
        OPC_STA_ZP  = 8'h85,
        OPC_STX_ZP  = 8'h86,
        OPC_STY_ZP  = 8'h84,
        OPC_JMP_ABS = 8'h4C
    } opcode_e;

    always_comb begin
        // anything not listed jams
        dec.op_class  = OP_BAD;
        dec.alu_op    = ALU_PASS;
        dec.src_sel   = REG_NONE;
        dec.dst_sel   = REG_NONE;
        dec.upd_c     = 1'b0;
        dec.set_c_val = 1'b0;

        case (dec.ir)
            // immediate loads pass the operand straight through
            OPC_LDA_IMM: {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMM, REG_M, REG_A};
            OPC_LDX_IMM: {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMM, REG_M, REG_X};
            OPC_LDY_IMM: {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMM, REG_M, REG_Y};
            // accumulator ops, operand comes from the bus
            OPC_ADC_IMM: begin
                {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMM, REG_A, REG_A};
                dec.alu_op = ALU_ADC;
                // carry taken from alu bit 8
                dec.upd_c  = 1'b1;
            end
            OPC_AND_IMM: begin
                {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMM, REG_A, REG_A};
                dec.alu_op = ALU_AND;
            end
            OPC_ORA_IMM: begin
                {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMM, REG_A, REG_A};
                dec.alu_op = ALU_ORA;
            end
            OPC_EOR_IMM: begin
                {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMM, REG_A, REG_A};
                dec.alu_op = ALU_EOR;
            end
            // increments, no flags
            OPC_INX: begin
                {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMPL, REG_X, REG_X};
                dec.alu_op = ALU_INC;
            end
            OPC_INY: begin
                {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMPL, REG_Y, REG_Y};
                dec.alu_op = ALU_INC;
            end
            // transfers
            OPC_TAX: {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMPL, REG_A, REG_X};
            OPC_TAY: {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMPL, REG_A, REG_Y};
            OPC_TXA: {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMPL, REG_X, REG_A};
            OPC_TYA: {dec.op_class, dec.src_sel, dec.dst_sel} = {OP_IMPL, REG_Y, REG_A};
            // carry set/clear, nothing written to a register
            OPC_CLC: begin
                {dec.op_class, dec.src_sel} = {OP_IMPL, REG_Z};
                dec.upd_c = 1'b1;
            end
            OPC_SEC: begin
                {dec.op_class, dec.src_sel} = {OP_IMPL, REG_Z};
                dec.upd_c     = 1'b1;
                dec.set_c_val = 1'b1;
            end
            OPC_NOP: dec.op_class = OP_IMPL;
            // zp stores, src picks the store byte
            OPC_STA_ZP: {dec.op_class, dec.src_sel} = {OP_STZ, REG_A};
            OPC_STX_ZP: {dec.op_class, dec.src_sel} = {OP_STZ, REG_X};
            OPC_STY_ZP: {dec.op_class, dec.src_sel} = {OP_STZ, REG_Y};
            OPC_JMP_ABS: dec.op_class = OP_JMP;
            default: dec.op_class = OP_BAD;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/seq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module seq_ctrl (
    input  wire logic                    clk_m1,
    input  wire logic                    rst,
    input  wire logic                    rdy_i,
    input  wire logic [`CORE_DATA_W-1:0] data_i,
    decode_if.seq_mp                     dec,
    output logic      [`CORE_ADDR_W-1:0] addr_o,
    output logic                         rw_o,
    output logic                         sync_o,
    output logic                         jam_o,
    output logic                         exec_en,
    output logic                         store_en
);

    import core_pkg::*;

    // where the next bus address comes from
    typedef enum logic [1:0] {
        ADR_PC,
        ADR_ZP,
        ADR_JMP,
        ADR_HOLD
    } addr_src_e;

    state_e                  state, state_nx;
    addr_src_e               addr_src;
    logic [`CORE_ADDR_W-1:0] pc, pc_nx;
    logic [`CORE_ADDR_W-1:0] addr_nx;
    logic [`CORE_ADDR_W-1:0] jmp_tgt;
    logic [`CORE_DATA_W-1:0] ir;
    logic [`CORE_DATA_W-1:0] jmp_lo;
    logic                    write_cyc;
    logic                    rdy;

    // only zp stores write, in their T3
    assign write_cyc = (state == T3) && (dec.op_class == OP_STZ);
    // ready only stalls reads
    assign rdy       = rdy_i | write_cyc;
    // high byte arrives in T3 of JMP
    assign jmp_tgt   = {data_i, jmp_lo};

    assign dec.ir   = ir;
    assign sync_o   = (state == T1);
    assign jam_o    = (state == T_JAM);
    assign rw_o     = ~write_cyc;
    assign store_en = write_cyc;
    // register update pulse, last cycle of imm/impl
    assign exec_en  = rdy_i && (state == T2) &&
                      ((dec.op_class == OP_IMM) || (dec.op_class == OP_IMPL));

    // pc always points one past the byte on the bus, except after impl
    always_comb begin
        state_nx = state;
        pc_nx    = pc;
        addr_src = ADR_HOLD;
        case (state)
            T1: begin
                // opcode on bus, move to next byte
                pc_nx    = pc + 1'b1;
                addr_src = ADR_PC;
                state_nx = T2;
            end
            T2: begin
                case (dec.op_class)
                    OP_IMM: begin
                        // operand consumed
                        pc_nx    = pc + 1'b1;
                        addr_src = ADR_PC;
                        state_nx = T1;
                    end
                    OP_IMPL: begin
                        // byte on bus is the next opcode, refetch it
                        addr_src = ADR_PC;
                        state_nx = T1;
                    end
                    OP_STZ: begin
                        pc_nx    = pc + 1'b1;
                        addr_src = ADR_ZP;
                        state_nx = T3;
                    end
                    OP_JMP: begin
                        // low byte latched below
                        pc_nx    = pc + 1'b1;
                        addr_src = ADR_PC;
                        state_nx = T3;
                    end
                    default: state_nx = T_JAM;
                endcase
            end
            T3: begin
                case (dec.op_class)
                    OP_JMP: begin
                        pc_nx    = jmp_tgt;
                        addr_src = ADR_JMP;
                        state_nx = T1;
                    end
                    OP_STZ: begin
                        addr_src = ADR_PC;
                        state_nx = T1;
                    end
                    default: state_nx = T_JAM;
                endcase
            end
            // jam: everything holds until reset
            default: state_nx = T_JAM;
        endcase
    end

    always_comb begin
        case (addr_src)
            ADR_PC:  addr_nx = pc_nx;
            ADR_ZP:  addr_nx = {`CORE_ZERO_PAGE, data_i};
            ADR_JMP: addr_nx = jmp_tgt;
            default: addr_nx = addr_o;
        endcase
    end

    always_ff @(posedge clk_m1) begin
        if (rst) begin
            state  <= T1;
            pc     <= `CORE_RESET_PC;
            addr_o <= `CORE_RESET_PC;
            ir     <= '0;
        end else if (rdy) begin
            state  <= state_nx;
            pc     <= pc_nx;
            addr_o <= addr_nx;
            // opcode capture on fetch
            if (state == T1) begin
                ir <= data_i;
            end
        end
    end

    // JMP low byte, read in T2
    always_ff @(posedge clk_m1) begin
        if (rdy && (state == T2)) begin
            jmp_lo <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module exec_unit (
    input  wire logic                    clk_m1,
    input  wire logic                    rst,
    input  wire logic                    rdy_i,
    input  wire logic                    exec_en,
    input  wire logic [`CORE_DATA_W-1:0] data_i,
    decode_if.exe_mp                     dec,
    output logic      [`CORE_DATA_W-1:0] store_data
);

    import core_pkg::*;

    logic [`CORE_DATA_W-1:0] a, x, y;
    logic                    c;
    logic [`CORE_DATA_W-1:0] src_val;
    logic [`CORE_DATA_W-1:0] alu_res;
    logic [`CORE_DATA_W:0]   sum;
    logic                    alu_c;

    // alu input A side
    always_comb begin
        case (dec.src_sel)
            REG_A:   src_val = a;
            REG_X:   src_val = x;
            REG_Y:   src_val = y;
            REG_M:   src_val = data_i;
            default: src_val = '0;
        endcase
    end

    // byte written on zp stores
    always_comb begin
        case (dec.src_sel)
            REG_A:   store_data = a;
            REG_X:   store_data = x;
            REG_Y:   store_data = y;
            default: store_data = '0;
        endcase
    end

    // 9 bit add, top bit is carry out
    assign sum   = {1'b0, src_val} + {1'b0, data_i} + {{`CORE_DATA_W{1'b0}}, c};
    assign alu_c = sum[`CORE_DATA_W];

    always_comb begin
        case (dec.alu_op)
            ALU_ADC: alu_res = sum[`CORE_DATA_W-1:0];
            ALU_AND: alu_res = src_val & data_i;
            ALU_ORA: alu_res = src_val | data_i;
            ALU_EOR: alu_res = src_val ^ data_i;
            // INX/INY, wraps at 255
            ALU_INC: alu_res = src_val + 1'b1;
            default: alu_res = src_val;
        endcase
    end

    // registers take the result at the end of the exec_en cycle
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            a <= '0;
            x <= '0;
            y <= '0;
            c <= 1'b0;
        end else if (exec_en && rdy_i) begin
            case (dec.dst_sel)
                REG_A:   a <= alu_res;
                REG_X:   x <= alu_res;
                REG_Y:   y <= alu_res;
                default: ;
            endcase
            // ADC takes alu carry, CLC/SEC the decoded value
            if (dec.upd_c) begin
                c <= (dec.alu_op == ALU_ADC) ? alu_c : dec.set_c_val;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module cpu_top (
    input  wire logic                    clk_m1,
    input  wire logic                    rst,
    input  wire logic                    rdy_i,
    input  wire logic [`CORE_DATA_W-1:0] data_i,
    output logic      [`CORE_ADDR_W-1:0] addr_o,
    output logic      [`CORE_DATA_W-1:0] dout_o,
    output logic                         rw_o,
    output logic                         sync_o,
    output logic                         jam_o
);

    logic                    exec_en;
    logic                    store_en;
    logic [`CORE_DATA_W-1:0] store_data;

    // decoded fields shared by the three blocks
    decode_if u_dec_if ();

    op_decode u_op_decode (
        .dec (u_dec_if.dec_mp)
    );

    seq_ctrl u_seq_ctrl (
        .clk_m1   (clk_m1),
        .rst      (rst),
        .rdy_i    (rdy_i),
        .data_i   (data_i),
        .dec      (u_dec_if.seq_mp),
        .addr_o   (addr_o),
        .rw_o     (rw_o),
        .sync_o   (sync_o),
        .jam_o    (jam_o),
        .exec_en  (exec_en),
        .store_en (store_en)
    );

    exec_unit u_exec_unit (
        .clk_m1     (clk_m1),
        .rst        (rst),
        .rdy_i      (rdy_i),
        .exec_en    (exec_en),
        .data_i     (data_i),
        .dec        (u_dec_if.exe_mp),
        .store_data (store_data)
    );

    // data out only carries a value on write cycles
    assign dout_o = store_en ? store_data : '0;

endmodule

`default_nettype wire

// ==== sim/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module tb_cpu;

    // program cycles with rdy_i always high and the jam tail
    localparam int PROG_CYCLES = 94;
    localparam int TIMEOUT_CYC = 4 * PROG_CYCLES + 200;
    localparam int N_STORES    = 11;
    localparam int MAIN_LEN    = 65;
    localparam int TGT_LEN     = 7;
    localparam logic [15:0] JMP_TGT  = 16'h0250;
    localparam logic [15:0] SENTINEL = 16'h001F;
    localparam logic [7:0]  JAM_BYTE = 8'h02;

    // loads, transfers, stores, then the carry chains, then JMP over a sentinel store
    localparam logic [7:0] MAIN_CODE [0:MAIN_LEN-1] = '{
        8'hA9, 8'h5A, 8'hAA, 8'hA0, 8'hC3, 8'h85, 8'h10, 8'h86, 8'h11, 8'h84, 8'h12,
        8'hA2, 8'h7E, 8'h8A, 8'h98, 8'hA9, 8'h11, 8'hA8, 8'hE8, 8'hC8,
        8'h85, 8'h13, 8'h86, 8'h14, 8'h84, 8'h15,
        8'h38, 8'hA9, 8'hF0, 8'h69, 8'h20, 8'h69, 8'h05, 8'h85, 8'h16,
        8'h18, 8'h69, 8'h01, 8'h29, 8'h3C, 8'h09, 8'hC1, 8'h49, 8'hFF, 8'h85, 8'h17,
        8'h38, 8'h69, 8'hFF, 8'h85, 8'h18, 8'hA9, 8'h00, 8'h69, 8'h00, 8'h85, 8'h19,
        8'h4C, 8'h50, 8'h02, 8'hA9, 8'hEE, 8'h85, 8'h1F, 8'h02
    };
    // jump target runs a NOP, wraps X through FF, stores it and jams
    localparam logic [7:0] TGT_CODE [0:TGT_LEN-1] = '{
        8'hEA, 8'hA2, 8'hFF, 8'hE8, 8'h86, 8'h1A, 8'h02
    };

    logic        clk_m1 = 1'b0;
    logic        rst;
    logic        rdy_i;
    logic [7:0]  data_i;
    logic [15:0] addr_o;
    logic [7:0]  dout_o;
    logic        rw_o;
    logic        sync_o;
    logic        jam_o;

    logic [7:0]  mem [0:65535];
    integer      seed = 26763;

    // reference model
    logic [7:0]  ma, mx, my;
    logic        mc;
    logic [15:0] exp_pc;
    logic [15:0] exp_waddr;
    logic [7:0]  exp_wdata;
    logic [7:0]  jam_opc;
    logic [15:0] addr_prev;
    logic        store_pend, bad_seen, first_cyc, stall_prev;
    int          writes_exp, writes_seen, jam_cycles, cycle_cnt;

    always #4 clk_m1 = ~clk_m1;

    cpu_top dut (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .rdy_i  (rdy_i),
        .data_i (data_i),
        .addr_o (addr_o),
        .dout_o (dout_o),
        .rw_o   (rw_o),
        .sync_o (sync_o),
        .jam_o  (jam_o)
    );

    // memory reads are async, writes land at the rising edge
    assign data_i = mem[addr_o];

    always @(posedge clk_m1) begin
        if (!rst && !rw_o) begin
            mem[addr_o] <= dout_o;
        end
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string sig, input logic [15:0] exp_v,
                                   input logic [15:0] act_v);
        abort_run($sformatf("error at %0t ns: %s expected %h, got %h",
                            $time, sig, exp_v, act_v));
    endtask

    task automatic expect_store(input logic [7:0] zp, input logic [7:0] val);
        store_pend = 1'b1;
        exp_waddr  = {8'h00, zp};
        exp_wdata  = val;
        writes_exp = writes_exp + 1;
    endtask

    // apply one instruction fetched at pc to the model
    task automatic step_model(input logic [15:0] pc);
        logic [7:0] opc;
        logic [7:0] opr;
        logic [8:0] sum;
        opc    = mem[pc];
        opr    = mem[pc + 16'd1];
        exp_pc = pc + 16'd2;
        case (opc)
            8'hA9: ma = opr;
            8'hA2: mx = opr;
            8'hA0: my = opr;
            // add with carry in and keep the ninth bit as the new carry
            8'h69: begin
                sum = {1'b0, ma} + {1'b0, opr} + {8'd0, mc};
                ma  = sum[7:0];
                mc  = sum[8];
            end
            8'h29: ma = ma & opr;
            8'h09: ma = ma | opr;
            8'h49: ma = ma ^ opr;
            8'hE8: mx = mx + 8'd1;
            8'hC8: my = my + 8'd1;
            8'hAA: mx = ma;
            8'hA8: my = ma;
            8'h8A: ma = mx;
            8'h98: ma = my;
            8'h18: mc = 1'b0;
            8'h38: mc = 1'b1;
            8'hEA: ;
            8'h85: expect_store(opr, ma);
            8'h86: expect_store(opr, mx);
            8'h84: expect_store(opr, my);
            8'h4C: exp_pc = {mem[pc + 16'd2], opr};
            default: begin
                bad_seen = 1'b1;
                jam_opc  = opc;
            end
        endcase
        // single byte instructions
        if (opc inside {8'hE8, 8'hC8, 8'hAA, 8'hA8, 8'h8A, 8'h98, 8'h18, 8'h38, 8'hEA}) begin
            exp_pc = pc + 16'd1;
        end
    endtask

    always @(posedge clk_m1) begin
        if (rst) begin
            {ma, mx, my, mc} = '0;
            exp_pc      = `CORE_RESET_PC;
            first_cyc   = 1'b1;
            {store_pend, bad_seen, stall_prev} = '0;
            jam_opc     = 8'h00;
            writes_exp  = 0;
            writes_seen = 0;
            jam_cycles  = 0;
            cycle_cnt   = 0;
        end else begin
            cycle_cnt = cycle_cnt + 1;
            if (first_cyc) begin
                assert (sync_o && rw_o && !jam_o)
                    else abort_run("first cycle after reset is not an opcode read");
                first_cyc = 1'b0;
            end
            // a stalled read must not move the bus
            if (stall_prev) begin
                assert (addr_o == addr_prev) else report_mismatch("addr_o", addr_prev, addr_o);
            end
            if (jam_o) begin
                assert (bad_seen) else abort_run("jam_o rose without an undefined opcode");
                assert (!sync_o) else report_mismatch("sync_o", 16'd0, {15'd0, sync_o});
                assert (rw_o) else report_mismatch("rw_o", 16'd1, {15'd0, rw_o});
                jam_cycles = jam_cycles + 1;
            end
            // completed opcode fetch
            if (sync_o && rdy_i) begin
                assert (!bad_seen) else abort_run("opcode fetch after an undefined opcode");
                assert (!store_pend) else abort_run("store never wrote before the next fetch");
                assert (rw_o) else report_mismatch("rw_o", 16'd1, {15'd0, rw_o});
                assert (addr_o == exp_pc) else report_mismatch("addr_o", exp_pc, addr_o);
                step_model(addr_o);
            end
            if (!rw_o) begin
                assert (addr_o != SENTINEL) else abort_run("skipped code wrote the sentinel");
                assert (store_pend) else abort_run("write cycle with no store pending");
                assert (addr_o == exp_waddr) else report_mismatch("addr_o", exp_waddr, addr_o);
                assert (dout_o == exp_wdata)
                    else report_mismatch("dout_o", {8'd0, exp_wdata}, {8'd0, dout_o});
                store_pend  = 1'b0;
                writes_seen = writes_seen + 1;
            end
            addr_prev  = addr_o;
            stall_prev = rw_o && !rdy_i;
        end
    end

    initial begin
        rst   = 1'b1;
        rdy_i = 1'b1;
        // fill depends on both address bytes
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ 8'h5C;
        end
        for (int i = 0; i < MAIN_LEN; i++) begin
            mem[`CORE_RESET_PC + i] = MAIN_CODE[i];
        end
        for (int i = 0; i < TGT_LEN; i++) begin
            mem[JMP_TGT + i] = TGT_CODE[i];
        end
        repeat (4) @(negedge clk_m1);
        rst = 1'b0;
        // ready is random and low about a quarter of the time
        while (jam_cycles < 4 && cycle_cnt < TIMEOUT_CYC) begin
            @(negedge clk_m1);
            rdy_i = (($random(seed) & 3) != 0);
            // every second store runs with ready low
            if (!rw_o && writes_seen[0]) begin
                rdy_i = 1'b0;
            end
        end
        if (cycle_cnt >= TIMEOUT_CYC) begin
            abort_run("timeout: core never settled in the jam state");
        end else if (writes_seen != writes_exp || writes_exp != N_STORES) begin
            abort_run("store count differs from the program");
        end else if (jam_opc != JAM_BYTE) begin
            abort_run("core jammed on an opcode other than the final jam byte");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
source/core_pkg.sv
source/decode_if.sv
source/op_decode.sv
source/seq_ctrl.sv
source/exec_unit.sv
source/cpu_top.sv
sim/tb_cpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cpu testbench with Verilator.
# The exit status is nonzero unless the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_cpu -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_cpu 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "=== PASS ==="; then
    exit 0
fi
exit 1
